//--- rtl/clk_pkg.sv
`default_nettype none

package clk_pkg;

   localparam int tick_cnt_w  = 32;  // Width of each tick counter
   localparam int reset_ticks = 16;  // Peripheral ticks that reset_out is held
   localparam int apb_addr_w  = 8;   // APB byte address width

   // Register byte offsets
   localparam logic [apb_addr_w-1:0] reg_ctrl       = apb_addr_w'('h00);
   localparam logic [apb_addr_w-1:0] reg_status     = apb_addr_w'('h04);
   localparam logic [apb_addr_w-1:0] reg_cpu_ticks  = apb_addr_w'('h08);
   localparam logic [apb_addr_w-1:0] reg_grom_ticks = apb_addr_w'('h0C);
   localparam logic [apb_addr_w-1:0] reg_vsp_ticks  = apb_addr_w'('h10);

   // Bit positions in reg_ctrl
   localparam int ctrl_turbo_bit      = 0;  // Read/write
   localparam int ctrl_soft_reset_bit = 1;  // Write one, self-clearing
   localparam int ctrl_clear_bit      = 2;  // Write one, self-clearing

   // Bit positions in reg_status
   localparam int status_reset_bit = 0;  // Current reset_out
   localparam int status_turbo_bit = 1;  // Turbo as applied

endpackage

`default_nettype wire

//--- rtl/clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module clkgen
   import clk_pkg::*;
#(
   parameter int clk_multiplier = 2,  // clk rate over the VGA pixel rate
   parameter int overlay_en     = 1   // Build the overlay pixel enable
) (
   input  logic clk,
   input  logic ext_reset_in,
   input  logic soft_reset,
   input  logic turbo,
   output logic reset_out,
   output logic vdp_clk_en,       // VDP pixel rate
   output logic vdp_clk_en_next,  // One cycle ahead of vdp_clk_en
   output logic vga_clk_en,       // Scan-doubler pixel rate
   output logic overlay_clk_en,   // Twice the VGA pixel rate
   output logic cpu_clk_en,
   output logic clk_3mhz_en,      // Peripheral rate, 3.58 MHz
   output logic grom_clk_en,      // Peripheral rate over 8
   output logic vsp_clk_en        // VGA rate over 67
);

   localparam int vdp_n = 2 * clk_multiplier;
   localparam int vga_n = clk_multiplier;
   localparam int per_n = 3 * clk_multiplier;

   // Rings start with the one in the top bit so no enable fires during reset
   localparam logic [vdp_n-1:0] vdp_start = vdp_n'(1) << (vdp_n - 1);
   localparam logic [vga_n-1:0] vga_start = vga_n'(1) << (vga_n - 1);
   localparam logic [per_n-1:0] per_start = per_n'(1) << (per_n - 1);

   logic [vdp_n-1:0] vdp_ring;
   logic [vga_n-1:0] vga_ring;
   logic [per_n-1:0] per_ring;
   logic [2:0]       grom_cnt;     // Counts peripheral ticks for GROM
   logic [6:0]       vsp_cnt;      // Modulo-67 on the VGA enable
   logic [4:0]       stretch_cnt;  // Peripheral ticks since reset release

   // Video, VGA and peripheral rings
   always_ff @(posedge clk) begin
      if (ext_reset_in) begin
         vdp_ring        <= vdp_start;
         vga_ring        <= vga_start;
         per_ring        <= per_start;
         vdp_clk_en      <= 1'b0;
         vdp_clk_en_next <= 1'b0;
         vga_clk_en      <= 1'b0;
         clk_3mhz_en     <= 1'b0;
      end else begin
         for (int i = 0; i < vdp_n; i++) begin
            vdp_ring[i] <= vdp_ring[(i + 1) % vdp_n];
         end
         for (int i = 0; i < vga_n; i++) begin
            vga_ring[i] <= vga_ring[(i + 1) % vga_n];
         end
         for (int i = 0; i < per_n; i++) begin
            per_ring[i] <= per_ring[(i + 1) % per_n];
         end
         vdp_clk_en      <= vdp_ring[0];
         vdp_clk_en_next <= vdp_ring[1];  // Reaches bit 0 one rotation later
         vga_clk_en      <= vga_ring[0];
         clk_3mhz_en     <= per_ring[0];
      end
   end

   // CPU and GROM gating, turbo forces both on every cycle
   always_ff @(posedge clk) begin
      if (ext_reset_in) begin
         grom_cnt    <= 3'd0;
         cpu_clk_en  <= 1'b0;
         grom_clk_en <= 1'b0;
      end else begin
         if (per_ring[0]) begin
            grom_cnt <= grom_cnt + 3'd1;
         end
         cpu_clk_en  <= turbo | per_ring[0];
         grom_clk_en <= turbo | (per_ring[0] && grom_cnt == 3'd7);
      end
   end

   // Speech processor enable
   always_ff @(posedge clk) begin
      if (ext_reset_in) begin
         vsp_cnt    <= 7'd0;
         vsp_clk_en <= 1'b0;
      end else begin
         vsp_clk_en <= 1'b0;
         if (vga_clk_en) begin
            if (vsp_cnt == 7'd66) begin
               vsp_cnt    <= 7'd0;
               vsp_clk_en <= 1'b1;  // One cycle after the 67th VGA pulse
            end else begin
               vsp_cnt <= vsp_cnt + 7'd1;
            end
         end
      end
   end

   // Reset stretcher, restarted by a software request as well
   always_ff @(posedge clk) begin
      if (ext_reset_in || soft_reset) begin
         stretch_cnt <= 5'd0;
         reset_out   <= 1'b1;
      end else if (reset_out && clk_3mhz_en) begin
         stretch_cnt <= stretch_cnt + 5'd1;
         if (stretch_cnt == 5'(reset_ticks - 1)) begin
            reset_out <= 1'b0;  // Released after the last counted tick
         end
      end
   end

   // Overlay pixel enable at half the VGA period
   generate
      if (overlay_en != 0) begin : g_overlay
         if (clk_multiplier % 2 != 0) begin : g_odd
            $fatal(1, "clkgen: overlay enable needs an even clk_multiplier");
            assign overlay_clk_en = 1'b0;
         end else begin : g_ring
            localparam int ovl_n = clk_multiplier / 2;
            localparam logic [ovl_n-1:0] ovl_start = ovl_n'(1) << (ovl_n - 1);

            logic [ovl_n-1:0] ovl_ring;
            logic             ovl_en_q;

            always_ff @(posedge clk) begin
               if (ext_reset_in) begin
                  ovl_ring <= ovl_start;
                  ovl_en_q <= 1'b0;
               end else begin
                  for (int i = 0; i < ovl_n; i++) begin
                     ovl_ring[i] <= ovl_ring[(i + 1) % ovl_n];
                  end
                  ovl_en_q <= ovl_ring[0];
               end
            end

            assign overlay_clk_en = ovl_en_q;
         end
      end else begin : g_no_overlay
         assign overlay_clk_en = 1'b0;
      end
   endgenerate

endmodule

`default_nettype wire

//--- rtl/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs
   import clk_pkg::*;
(
   input  logic                  clk,
   input  logic                  ext_reset_in,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pslverr,
   input  logic                  reset_out,
   input  logic [tick_cnt_w-1:0] cpu_ticks,
   input  logic [tick_cnt_w-1:0] grom_ticks,
   input  logic [tick_cnt_w-1:0] vsp_ticks,
   output logic                  turbo,
   output logic                  soft_reset,   // One-cycle pulse
   output logic                  count_clear   // One-cycle pulse
);

   logic        access;    // APB access phase
   logic        ctrl_wr;   // Write to reg_ctrl completes this cycle
   logic        addr_hit;  // Offset is mapped
   logic [31:0] rd_mux;

   assign access  = psel & penable;
   assign ctrl_wr = access & pwrite & (paddr == reg_ctrl);

   // Address decode and read data select
   always_comb begin
      addr_hit = 1'b1;
      rd_mux   = '0;
      case (paddr)
         reg_ctrl: begin
            rd_mux[ctrl_turbo_bit] = turbo;  // Pulse bits read back as zero
         end
         reg_status: begin
            rd_mux[status_reset_bit] = reset_out;
            rd_mux[status_turbo_bit] = turbo;
         end
         reg_cpu_ticks: begin
            rd_mux = 32'(cpu_ticks);
         end
         reg_grom_ticks: begin
            rd_mux = 32'(grom_ticks);
         end
         reg_vsp_ticks: begin
            rd_mux = 32'(vsp_ticks);
         end
         default: begin
            addr_hit = 1'b0;
         end
      endcase
   end

   // Zero-wait slave, so data and error are valid in the access cycle
   assign prdata  = (psel && !pwrite) ? rd_mux : '0;
   assign pslverr = access & ~addr_hit;

   // Control register, write-one bits become single-cycle pulses
   always_ff @(posedge clk) begin
      if (ext_reset_in) begin
         turbo       <= 1'b0;
         soft_reset  <= 1'b0;
         count_clear <= 1'b0;
      end else begin
         soft_reset  <= ctrl_wr & pwdata[ctrl_soft_reset_bit];
         count_clear <= ctrl_wr & pwdata[ctrl_clear_bit];
         if (ctrl_wr) begin
            turbo <= pwdata[ctrl_turbo_bit];
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/tick_counters.sv
`timescale 1ns/1ps
`default_nettype none

module tick_counters
   import clk_pkg::*;
(
   input  logic                  clk,
   input  logic                  ext_reset_in,
   input  logic                  count_clear,
   input  logic                  cpu_clk_en,
   input  logic                  grom_clk_en,
   input  logic                  vsp_clk_en,
   output logic [tick_cnt_w-1:0] cpu_ticks,
   output logic [tick_cnt_w-1:0] grom_ticks,
   output logic [tick_cnt_w-1:0] vsp_ticks
);

   localparam int num_cnt = 3;

   logic [num_cnt-1:0]    en_vec;          // Watched enables, CPU in bit 0
   logic [tick_cnt_w-1:0] cnt [num_cnt];

   assign en_vec = {vsp_clk_en, grom_clk_en, cpu_clk_en};

   // Clear wins over a coinciding enable
   always_ff @(posedge clk) begin
      for (int i = 0; i < num_cnt; i++) begin
         if (ext_reset_in || count_clear) begin
            cnt[i] <= '0;
         end else if (en_vec[i]) begin
            cnt[i] <= cnt[i] + tick_cnt_w'(1);  // Wraps at full scale
         end
      end
   end

   assign cpu_ticks  = cnt[0];
   assign grom_ticks = cnt[1];
   assign vsp_ticks  = cnt[2];

endmodule

`default_nettype wire

//--- rtl/clock_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module clock_sys_top
   import clk_pkg::*;
#(
   parameter int clk_multiplier = 2,  // clk rate over the VGA pixel rate
   parameter int overlay_en     = 1   // Needs an even clk_multiplier
) (
   input  logic                  clk,
   input  logic                  ext_reset_in,
   // APB3 slave
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pslverr,
   // Clock enables
   output logic                  reset_out,
   output logic                  vdp_clk_en,
   output logic                  vdp_clk_en_next,
   output logic                  vga_clk_en,
   output logic                  overlay_clk_en,
   output logic                  cpu_clk_en,
   output logic                  clk_3mhz_en,
   output logic                  grom_clk_en,
   output logic                  vsp_clk_en
);

   logic                  turbo;
   logic                  soft_reset;
   logic                  count_clear;
   logic [tick_cnt_w-1:0] cpu_ticks;
   logic [tick_cnt_w-1:0] grom_ticks;
   logic [tick_cnt_w-1:0] vsp_ticks;

   clkgen #(
      .clk_multiplier (clk_multiplier),
      .overlay_en     (overlay_en)
   ) i_clkgen (
      .clk             (clk),
      .ext_reset_in    (ext_reset_in),
      .soft_reset      (soft_reset),
      .turbo           (turbo),
      .reset_out       (reset_out),
      .vdp_clk_en      (vdp_clk_en),
      .vdp_clk_en_next (vdp_clk_en_next),
      .vga_clk_en      (vga_clk_en),
      .overlay_clk_en  (overlay_clk_en),
      .cpu_clk_en      (cpu_clk_en),
      .clk_3mhz_en     (clk_3mhz_en),
      .grom_clk_en     (grom_clk_en),
      .vsp_clk_en      (vsp_clk_en)
   );

   apb_regs i_apb_regs (
      .clk          (clk),
      .ext_reset_in (ext_reset_in),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pslverr      (pslverr),
      .reset_out    (reset_out),
      .cpu_ticks    (cpu_ticks),
      .grom_ticks   (grom_ticks),
      .vsp_ticks    (vsp_ticks),
      .turbo        (turbo),
      .soft_reset   (soft_reset),
      .count_clear  (count_clear)
   );

   tick_counters i_tick_counters (
      .clk          (clk),
      .ext_reset_in (ext_reset_in),
      .count_clear  (count_clear),
      .cpu_clk_en   (cpu_clk_en),
      .grom_clk_en  (grom_clk_en),
      .vsp_clk_en   (vsp_clk_en),
      .cpu_ticks    (cpu_ticks),
      .grom_ticks   (grom_ticks),
      .vsp_ticks    (vsp_ticks)
   );

endmodule

`default_nettype wire

//--- verif/clock_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clock_sys_tb
   import clk_pkg::*;
();

   localparam int clk_multiplier = 2;
   localparam int overlay_en     = 1;
   localparam int timeout_cycles = 20000;  // Far above the longest run
   localparam int m              = clk_multiplier;
   // Periods of vga, vdp, overlay and peripheral enables, in that order
   localparam int period [4]     = '{m, 2 * m, m / 2, 3 * m};

   logic                  clk;
   logic                  ext_reset_in;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [apb_addr_w-1:0] paddr;
   logic [31:0]           pwdata;
   logic [31:0]           prdata;
   logic                  pslverr;
   logic                  reset_out;
   logic                  vdp_clk_en;
   logic                  vdp_clk_en_next;
   logic                  vga_clk_en;
   logic                  overlay_clk_en;
   logic                  cpu_clk_en;
   logic                  clk_3mhz_en;
   logic                  grom_clk_en;
   logic                  vsp_clk_en;

   logic        ctrl_wr;     // Control write completes at the next edge
   logic        rd_access;   // APB read access cycle
   logic        m_turbo;     // Turbo as held by the register
   logic        m_soft;      // Expected soft reset pulse
   logic        m_clear;     // Expected counter clear pulse
   logic        turbo_d;     // Turbo one cycle late, as seen by the gating
   logic        vga_d;
   logic        vdp_next_d;
   logic        exp_reset;
   int          n_str;       // Peripheral ticks in the current stretch
   int          n3;          // Peripheral ticks since ext reset
   int          nvga;        // VGA pulses modulo 67
   logic [31:0] cpu_tally;
   logic [31:0] grom_tally;
   logic [31:0] vsp_tally;
   logic [3:0]  per_en;
   logic [15:0] lfsr;
   int          cycle_cnt = 0;

   clock_sys_top #(
      .clk_multiplier (clk_multiplier),
      .overlay_en     (overlay_en)
   ) i_dut (
      .clk             (clk),
      .ext_reset_in    (ext_reset_in),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .paddr           (paddr),
      .pwdata          (pwdata),
      .prdata          (prdata),
      .pslverr         (pslverr),
      .reset_out       (reset_out),
      .vdp_clk_en      (vdp_clk_en),
      .vdp_clk_en_next (vdp_clk_en_next),
      .vga_clk_en      (vga_clk_en),
      .overlay_clk_en  (overlay_clk_en),
      .cpu_clk_en      (cpu_clk_en),
      .clk_3mhz_en     (clk_3mhz_en),
      .grom_clk_en     (grom_clk_en),
      .vsp_clk_en      (vsp_clk_en)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic end_in_failure();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic report_mismatch(input string test, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
      end_in_failure();
   endtask

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);  // Galois taps 16,14,13,11
   endfunction

   // One LFSR step for each bit taken
   task automatic draw_random(input int nbits, output int value);
      value = 0;
      for (int i = 0; i < nbits; i++) begin
         lfsr  = lfsr_next(lfsr);
         value = (value << 1) | int'(lfsr[0]);
      end
   endtask

   function automatic logic is_mapped(input logic [apb_addr_w-1:0] addr);
      return addr == reg_ctrl || addr == reg_status || addr == reg_cpu_ticks ||
             addr == reg_grom_ticks || addr == reg_vsp_ticks;
   endfunction

   function automatic string period_name(input int idx);
      case (idx)
         0:       return "vga_clk_en period";
         1:       return "vdp_clk_en period";
         2:       return "overlay_clk_en period";
         default: return "clk_3mhz_en period";
      endcase
   endfunction

   task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;  // Setup cycle
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;  // Access cycle
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [apb_addr_w-1:0] addr);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;  // prdata is checked in this cycle
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic idle_gap();
      int n;
      draw_random(3, n);
      repeat (n + 1) @(posedge clk);
   endtask

   task automatic wait_reset_release();
      do begin
         @(negedge clk);
      end while (reset_out);
   endtask

   assign ctrl_wr   = psel && penable && pwrite && paddr == reg_ctrl;
   assign rd_access = psel && penable && !pwrite;
   assign exp_reset = n_str < reset_ticks;
   assign per_en    = {clk_3mhz_en, overlay_clk_en, vdp_clk_en, vga_clk_en};

   // Reference model built from the register map and timing rules
   always @(posedge clk) begin
      if (ext_reset_in) begin
         m_turbo    <= 1'b0;
         m_soft     <= 1'b0;
         m_clear    <= 1'b0;
         turbo_d    <= 1'b0;
         vga_d      <= 1'b0;
         vdp_next_d <= 1'b0;
         n_str      <= 0;
         n3         <= 0;
         nvga       <= 0;
         cpu_tally  <= '0;
         grom_tally <= '0;
         vsp_tally  <= '0;
      end else begin
         m_soft     <= ctrl_wr && pwdata[ctrl_soft_reset_bit];
         m_clear    <= ctrl_wr && pwdata[ctrl_clear_bit];
         if (ctrl_wr) begin
            m_turbo <= pwdata[ctrl_turbo_bit];
         end
         turbo_d    <= m_turbo;
         vga_d      <= vga_clk_en;
         vdp_next_d <= vdp_clk_en_next;
         if (clk_3mhz_en) begin
            n3 <= n3 + 1;
         end
         if (vga_clk_en) begin
            nvga <= (nvga == 66) ? 0 : nvga + 1;
         end
         if (m_soft) begin
            n_str <= 0;  // Stretch restarts
         end else if (clk_3mhz_en && n_str < reset_ticks) begin
            n_str <= n_str + 1;
         end
         if (m_clear) begin
            cpu_tally  <= '0;
            grom_tally <= '0;
            vsp_tally  <= '0;
         end else begin
            cpu_tally  <= cpu_tally + 32'(cpu_clk_en);
            grom_tally <= grom_tally + 32'(grom_clk_en);
            vsp_tally  <= vsp_tally + 32'(vsp_clk_en);
         end
      end
   end

   // Fixed-period enables, checked once the first pulse has been seen
   for (genvar g = 0; g < 4; g++) begin : g_period
      int   gap;
      logic seen;

      always @(posedge clk) begin
         if (ext_reset_in) begin
            gap  <= 0;
            seen <= 1'b0;
         end else if (per_en[g]) begin
            gap  <= 1;
            seen <= 1'b1;
         end else begin
            gap <= gap + 1;
         end
      end

      assert property (@(negedge clk) disable iff (ext_reset_in || !seen)
                       per_en[g] == (gap == period[g]))
         else report_mismatch(period_name(g), 32'(gap == period[g]), 32'(per_en[g]));
   end

   assert property (@(negedge clk) disable iff (ext_reset_in) vdp_clk_en == vdp_next_d)
      else report_mismatch("vdp_clk_en_next lead", 32'(vdp_next_d), 32'(vdp_clk_en));

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    cpu_clk_en == (turbo_d | clk_3mhz_en))
      else report_mismatch("cpu_clk_en gating", 32'(turbo_d | clk_3mhz_en), 32'(cpu_clk_en));

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    grom_clk_en == (turbo_d | (clk_3mhz_en && n3 % 8 == 7)))
      else report_mismatch("grom_clk_en gating",
                           32'(turbo_d | (clk_3mhz_en && n3 % 8 == 7)), 32'(grom_clk_en));

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    vsp_clk_en == (vga_d && nvga == 0))
      else report_mismatch("vsp_clk_en period", 32'(vga_d && nvga == 0), 32'(vsp_clk_en));

   assert property (@(negedge clk) disable iff (ext_reset_in) reset_out == exp_reset)
      else report_mismatch("reset stretch", 32'(exp_reset), 32'(reset_out));

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    pslverr == (psel && penable && !is_mapped(paddr)))
      else report_mismatch("pslverr", 32'(psel && penable && !is_mapped(paddr)),
                           32'(pslverr));

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    !(rd_access && paddr == reg_ctrl) || prdata == 32'(m_turbo))
      else report_mismatch("ctrl read", 32'(m_turbo), prdata);

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    !(rd_access && paddr == reg_status) ||
                    prdata == {30'd0, m_turbo, exp_reset})
      else report_mismatch("status read", {30'd0, m_turbo, exp_reset}, prdata);

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    !(rd_access && paddr == reg_cpu_ticks) || prdata == cpu_tally)
      else report_mismatch("cpu tick count", cpu_tally, prdata);

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    !(rd_access && paddr == reg_grom_ticks) || prdata == grom_tally)
      else report_mismatch("grom tick count", grom_tally, prdata);

   assert property (@(negedge clk) disable iff (ext_reset_in)
                    !(rd_access && paddr == reg_vsp_ticks) || prdata == vsp_tally)
      else report_mismatch("vsp tick count", vsp_tally, prdata);

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == timeout_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
         end_in_failure();
      end
   end

   initial begin
      int n;
      lfsr         = 16'd37608;
      ext_reset_in <= 1'b1;
      psel         <= 1'b0;
      penable      <= 1'b0;
      pwrite       <= 1'b0;
      paddr        <= '0;
      pwdata       <= '0;
      repeat (8) @(posedge clk);
      ext_reset_in <= 1'b0;
      wait_reset_release();

      // Free-running enables, long enough for several speech pulses
      draw_random(8, n);
      repeat (300 + n) @(posedge clk);

      // Counter clear, then a random window before reading the tallies
      apb_write(reg_ctrl, 32'h4);
      draw_random(8, n);
      repeat (150 + n) @(posedge clk);
      apb_read(reg_cpu_ticks);
      idle_gap();
      apb_read(reg_grom_ticks);
      idle_gap();
      apb_read(reg_vsp_ticks);

      // Turbo on and off
      apb_write(reg_ctrl, 32'h1);
      idle_gap();
      apb_read(reg_status);
      apb_read(reg_ctrl);
      apb_write(reg_ctrl, 32'h5);  // Clear lands on a cycle with CPU and GROM enables
      draw_random(6, n);
      repeat (20 + n) @(posedge clk);
      apb_read(reg_cpu_ticks);
      apb_read(reg_grom_ticks);
      apb_write(reg_ctrl, 32'h0);
      repeat (60) @(posedge clk);
      apb_read(reg_status);

      // Soft reset restarts the stretch
      idle_gap();
      apb_write(reg_ctrl, 32'h2);
      apb_read(reg_status);
      wait_reset_release();
      apb_read(reg_status);

      // Unmapped offset, then a mapped one
      idle_gap();
      apb_read(8'h20);
      idle_gap();
      apb_write(8'h20, 32'hFFFF_FFFF);
      idle_gap();
      apb_read(reg_ctrl);
      repeat (10) @(posedge clk);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
rtl/clk_pkg.sv
rtl/clkgen.sv
rtl/apb_regs.sv
rtl/tick_counters.sv
rtl/clock_sys_top.sv
verif/clock_sys_tb.sv

//--- Makefile
TOP := clock_sys_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f -Mdir obj_dir

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
